//--- Makefile
# Verilator build and run of the AIB channel testbench
VERILATOR   ?= verilator
TOP         ?= aib_tb
FILELIST    ?= build.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --binary --timing --assert
PASS_STRING ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STRING)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
design/aib_pkg.sv
design/aib_csr.sv
design/aib_io_buffer.sv
design/aib_channel.sv
verification/aib_props.sv
verification/aib_checker.sv
verification/aib_tb.sv

//--- design/aib_channel.sv
// Four-lane channel top; configuration only through the Wishbone CSR and pads exposed as split ports
module aib_channel
(
   input  logic                           ilaunch_clk,
   input  logic                           irstb,
   // Wishbone classic
   input  logic                           wb_cyc,
   input  logic                           wb_stb,
   input  logic                           wb_we,
   input  logic [aib_pkg::ADR_W-1:0]      wb_adr,
   input  logic [aib_pkg::DAT_W-1:0]      wb_wdata,
   output logic [aib_pkg::DAT_W-1:0]      wb_rdata,
   output logic                           wb_ack,
   // MAC transmit side
   input  logic [aib_pkg::NUM_LANES-1:0]  tx_dat0,
   input  logic [aib_pkg::NUM_LANES-1:0]  tx_dat1,
   input  logic [aib_pkg::NUM_LANES-1:0]  async_data,
   // Far side of the pads
   input  logic [aib_pkg::NUM_LANES-1:0]  pad_in,
   input  logic [aib_pkg::NUM_LANES-1:0]  pad_ext_en,
   // MAC receive side
   output logic [aib_pkg::NUM_LANES-1:0]  rx_dat0,
   output logic [aib_pkg::NUM_LANES-1:0]  rx_dat1,
   output logic [aib_pkg::NUM_LANES-1:0]  rx_async,
   // Pad drivers
   output logic [aib_pkg::NUM_LANES-1:0]  pad_out,
   output logic [aib_pkg::NUM_LANES-1:0]  pad_oe
);
   import aib_pkg::*;

   // --------------------------------------------------
   // CSR to lane wiring
   // --------------------------------------------------
   logic [NUM_LANES-1:0] lane_txen;
   logic [NUM_LANES-1:0] lane_rxen;
   logic [NUM_LANES-1:0] lane_weaken;
   logic [NUM_LANES-1:0] lane_weakdir;
   io_mode_e             lane_mode [NUM_LANES];

   aib_csr i_aib_csr
   (
      .ilaunch_clk  (ilaunch_clk),
      .irstb        (irstb),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_we        (wb_we),
      .wb_adr       (wb_adr),
      .wb_wdata     (wb_wdata),
      .wb_rdata     (wb_rdata),
      .wb_ack       (wb_ack),
      .rx_async     (rx_async),   // Status readback of resolved pads
      .lane_txen    (lane_txen),
      .lane_rxen    (lane_rxen),
      .lane_weaken  (lane_weaken),
      .lane_weakdir (lane_weakdir),
      .lane_mode    (lane_mode)
   );

   // --------------------------------------------------
   // One buffer per lane
   // --------------------------------------------------
   for (genvar i = 0; i < NUM_LANES; i++)
   begin : g_lane
      aib_io_buffer i_aib_io_buffer
      (
         .ilaunch_clk (ilaunch_clk),
         .irstb       (irstb),
         .txen        (lane_txen[i]),
         .rxen        (lane_rxen[i]),
         .weaken      (lane_weaken[i]),
         .weakdir     (lane_weakdir[i]),
         .mode        (lane_mode[i]),
         .dat0        (tx_dat0[i]),
         .dat1        (tx_dat1[i]),
         .async_data  (async_data[i]),
         .pad_in      (pad_in[i]),
         .pad_ext_en  (pad_ext_en[i]),
         .pad_out     (pad_out[i]),
         .pad_oe      (pad_oe[i]),
         .rx_dat0     (rx_dat0[i]),
         .rx_dat1     (rx_dat1[i]),
         .rx_async    (rx_async[i])
      );
   end

endmodule

//--- design/aib_csr.sv
// Wishbone classic slave without stall; master holds its request until ack and rdata is combinational
module aib_csr
(
   input  logic                           ilaunch_clk,
   input  logic                           irstb,
   // Wishbone classic
   input  logic                           wb_cyc,
   input  logic                           wb_stb,
   input  logic                           wb_we,
   input  logic [aib_pkg::ADR_W-1:0]      wb_adr,
   input  logic [aib_pkg::DAT_W-1:0]      wb_wdata,
   output logic [aib_pkg::DAT_W-1:0]      wb_rdata,
   output logic                           wb_ack,
   // Pad levels back from the buffers
   input  logic [aib_pkg::NUM_LANES-1:0]  rx_async,
   // Per-lane configuration
   output logic [aib_pkg::NUM_LANES-1:0]  lane_txen,
   output logic [aib_pkg::NUM_LANES-1:0]  lane_rxen,
   output logic [aib_pkg::NUM_LANES-1:0]  lane_weaken,
   output logic [aib_pkg::NUM_LANES-1:0]  lane_weakdir,
   output aib_pkg::io_mode_e              lane_mode [aib_pkg::NUM_LANES]
);
   import aib_pkg::*;

   logic [DAT_W-1:0]      cfg_q [NUM_LANES];   // One config byte per lane
   logic [NUM_LANES-1:0]  status_q;            // rx_async, one cycle old
   logic                  ack_q;
   logic                  req;                 // New access this cycle
   reg_addr_e             addr;
   logic [LANE_IDX_W-1:0] lane_sel;
   logic [DAT_W-1:0]      rdata_mux;

   // --------------------------------------------------
   // Bus handshake
   // --------------------------------------------------
   assign req      = wb_cyc & wb_stb & ~ack_q;   // Low while ack shows, so one ack per request
   assign addr     = reg_addr_e'(wb_adr);
   assign lane_sel = wb_adr[LANE_IDX_W-1:0];

   always_ff @(posedge ilaunch_clk)
   begin
      if (!irstb)
         ack_q <= 1'b0;
      else
         ack_q <= req;   // Single-cycle pulse
   end

   assign wb_ack = ack_q;

   // --------------------------------------------------
   // Config and status registers
   // --------------------------------------------------
   always_ff @(posedge ilaunch_clk)
   begin
      if (!irstb)
      begin
         for (int i = 0; i < NUM_LANES; i++)
            cfg_q[i] <= '0;   // All lanes off, pad undriven
         status_q <= '0;
      end
      else
      begin
         status_q <= rx_async;   // Sampled every cycle
         // Write lands on the same edge that raises ack
         if (req && wb_we && (addr inside {ADDR_CFG0, ADDR_CFG1, ADDR_CFG2, ADDR_CFG3}))
            cfg_q[lane_sel] <= wb_wdata & CFG_MASK;
      end
   end

   // Read mux, unmapped reads 0
   always_comb
   begin
      rdata_mux = '0;
      case (addr)
         ADDR_CFG0, ADDR_CFG1, ADDR_CFG2, ADDR_CFG3:
            rdata_mux = cfg_q[lane_sel];
         ADDR_STATUS:
            rdata_mux = {{(DAT_W-NUM_LANES){1'b0}}, status_q};
         default:
            rdata_mux = '0;
      endcase
   end

   assign wb_rdata = rdata_mux;   // Address held by master through the ack cycle

   // --------------------------------------------------
   // Unpack config bytes onto lane buses
   // --------------------------------------------------
   for (genvar i = 0; i < NUM_LANES; i++)
   begin : g_unpack
      assign lane_txen[i]    = cfg_q[i][CFG_TXEN_BIT];
      assign lane_rxen[i]    = cfg_q[i][CFG_RXEN_BIT];
      assign lane_weaken[i]  = cfg_q[i][CFG_WEAKEN_BIT];
      assign lane_weakdir[i] = cfg_q[i][CFG_WEAKDIR_BIT];
      assign lane_mode[i]    = io_mode_e'(cfg_q[i][CFG_MODE_MSB:CFG_MODE_LSB]);
   end

endmodule

//--- design/aib_io_buffer.sv
// One lane on split pad ports with the pad level resolved locally; tx and rx share both edges of ilaunch_clk
module aib_io_buffer
(
   input  logic               ilaunch_clk,
   input  logic               irstb,
   // Lane configuration
   input  logic               txen,
   input  logic               rxen,
   input  logic               weaken,       // Weak keeper on undriven pad
   input  logic               weakdir,      // Keeper level
   input  aib_pkg::io_mode_e  mode,
   // From the MAC
   input  logic               dat0,
   input  logic               dat1,
   input  logic               async_data,
   // Far side of the pad
   input  logic               pad_in,
   input  logic               pad_ext_en,   // Far side drives the pad
   output logic               pad_out,
   output logic               pad_oe,
   // To the MAC
   output logic               rx_dat0,
   output logic               rx_dat1,
   output logic               rx_async
);
   import aib_pkg::*;

   logic is_ddr;
   logic is_async;      // Everything else runs as SDR
   logic tx_hold0;      // dat0 from last rising edge
   logic tx_hold1;      // dat1 from last rising edge
   logic tx_hi_val;     // Level wanted for the coming high phase
   logic tx_rise;       // Rising half of the XOR pair
   logic tx_fall;       // Falling half of the XOR pair
   logic tx_sync;
   logic pad_lvl;       // Resolved pad
   logic rx_rise;       // Pad sampled at rising edge
   logic rx_fall;       // Pad sampled at falling edge
   logic rx_d0_q;
   logic rx_d1_q;

   assign is_ddr   = (mode == MODE_DDR);
   assign is_async = (mode == MODE_ASYNC);

   // --------------------------------------------------
   // Transmit
   // --------------------------------------------------
   // Pad level is tx_rise ^ tx_fall, so each edge sets its own half-cycle
   // and the pad only moves through register updates
   assign tx_hi_val = is_ddr ? tx_hold1 : dat0;   // DDR high phase carries previous dat1

   always_ff @(posedge ilaunch_clk)
   begin
      if (!irstb)
      begin
         tx_hold0 <= 1'b0;
         tx_hold1 <= 1'b0;
         tx_rise  <= 1'b0;
      end
      else
      begin
         tx_hold0 <= dat0;
         tx_hold1 <= dat1;
         tx_rise  <= tx_hi_val ^ tx_fall;   // Pad becomes tx_hi_val
      end
   end

   // Low phase always carries dat0 of the last rising edge
   always_ff @(negedge ilaunch_clk)
   begin
      if (!irstb)
         tx_fall <= 1'b0;
      else
         tx_fall <= tx_hold0 ^ tx_rise;      // Pad becomes tx_hold0
   end

   assign tx_sync = tx_rise ^ tx_fall;

   // Mode mux, held low when the driver is off
   assign pad_out = txen & (is_async ? async_data : tx_sync);
   assign pad_oe  = txen;

   // --------------------------------------------------
   // Pad resolution
   // --------------------------------------------------
   always_comb
   begin
      if (txen)
         pad_lvl = pad_out;       // Own driver wins
      else if (pad_ext_en)
         pad_lvl = pad_in;        // Far side driving
      else if (weaken)
         pad_lvl = weakdir;       // Pull-up or pull-down
      else
         pad_lvl = 1'b0;          // Floating pad reads low
   end

   // --------------------------------------------------
   // Receive
   // --------------------------------------------------
   always_ff @(negedge ilaunch_clk)
   begin
      if (!irstb)
         rx_fall <= 1'b0;
      else if (rxen)
         rx_fall <= pad_lvl;     // SDR data, or DDR dat1
   end

   always_ff @(posedge ilaunch_clk)
   begin
      if (!irstb)
      begin
         rx_rise <= 1'b0;
         rx_d0_q <= 1'b0;
         rx_d1_q <= 1'b0;
      end
      else if (rxen)             // Hold everything while rx is off
      begin
         rx_rise <= pad_lvl;                       // DDR dat0
         rx_d0_q <= is_ddr ? rx_rise : rx_fall;    // DDR 2 cycles, SDR 1 cycle
         rx_d1_q <= is_ddr & rx_fall;              // Zero outside DDR
      end
   end

   assign rx_dat0  = rxen & rx_d0_q;
   assign rx_dat1  = rxen & rx_d1_q;
   assign rx_async = rxen & pad_lvl;   // No clock in this path

endmodule

//--- design/aib_pkg.sv
// Shared lane count, Wishbone widths and encodings; the CSR address map assumes at most four lanes
package aib_pkg;

   // --------------------------------------------------
   // Channel and bus sizing
   // --------------------------------------------------
   localparam int NUM_LANES  = 4;                  // Pad lanes, one bit each on lane buses
   localparam int LANE_IDX_W = $clog2(NUM_LANES);  // Lane select out of the CSR address
   localparam int ADR_W      = 3;                  // Wishbone byte address
   localparam int DAT_W      = 8;                  // Wishbone data
   localparam int MODE_W     = 2;                  // Lane mode code

   // Lane transmit mode, code 3 unused and treated as SDR
   typedef enum logic [MODE_W-1:0] {
      MODE_SDR   = 2'd0,   // dat0 launched on rising edge
      MODE_DDR   = 2'd1,   // dat0 low phase, dat1 high phase
      MODE_ASYNC = 2'd2    // async_data straight to pad
   } io_mode_e;

   // Register map
   typedef enum logic [ADR_W-1:0] {
      ADDR_CFG0   = 3'd0,
      ADDR_CFG1   = 3'd1,
      ADDR_CFG2   = 3'd2,
      ADDR_CFG3   = 3'd3,
      ADDR_STATUS = 3'd4   // Resolved pad levels, read only
   } reg_addr_e;

   // --------------------------------------------------
   // Config byte layout
   // --------------------------------------------------
   localparam int CFG_TXEN_BIT    = 0;
   localparam int CFG_RXEN_BIT    = 1;
   localparam int CFG_MODE_LSB    = 2;
   localparam int CFG_MODE_MSB    = 3;
   localparam int CFG_WEAKEN_BIT  = 4;
   localparam int CFG_WEAKDIR_BIT = 5;   // 1 pulls up, 0 pulls down
   localparam logic [DAT_W-1:0] CFG_MASK = 8'h3f;   // Bits 7:6 never stored

endpackage

//--- verification/aib_checker.sv
// Samples DUT ports on rising edges only; clocked checks wait 4 cycles after each config write
module aib_checker
(
   input logic                           ilaunch_clk,
   input logic                           irstb,
   input logic                           wb_cyc,
   input logic                           wb_stb,
   input logic                           wb_we,
   input logic [aib_pkg::ADR_W-1:0]      wb_adr,
   input logic [aib_pkg::DAT_W-1:0]      wb_wdata,
   input logic [aib_pkg::DAT_W-1:0]      wb_rdata,
   input logic                           wb_ack,
   input logic [aib_pkg::NUM_LANES-1:0]  tx_dat0,
   input logic [aib_pkg::NUM_LANES-1:0]  tx_dat1,
   input logic [aib_pkg::NUM_LANES-1:0]  async_data,
   input logic [aib_pkg::NUM_LANES-1:0]  pad_in,
   input logic [aib_pkg::NUM_LANES-1:0]  pad_ext_en,
   input logic [aib_pkg::NUM_LANES-1:0]  rx_dat0,
   input logic [aib_pkg::NUM_LANES-1:0]  rx_dat1,
   input logic [aib_pkg::NUM_LANES-1:0]  rx_async,
   input logic [aib_pkg::NUM_LANES-1:0]  pad_out,
   input logic [aib_pkg::NUM_LANES-1:0]  pad_oe,
   input int                             test_num
);
   timeunit 1ns;
   timeprecision 100ps;
   import aib_pkg::*;

   logic [DAT_W-1:0]     cfg [NUM_LANES];              // Mirror of the config bytes
   logic [NUM_LANES-1:0] d0_h [3];                     // tx_dat0 of the last 3 edges, newest at 0
   logic [NUM_LANES-1:0] d1_h [3];
   logic [NUM_LANES-1:0] prev_rx;                      // Modelled rx_async at previous edge
   logic [NUM_LANES-1:0] e_pad, e_lvl, e_d0, e_d1, e_oe;
   logic [NUM_LANES-1:0] m_pad, m_rxd;                 // Lanes whose value is predictable
   logic                 e_ack;                        // Ack expected in the coming cycle
   int                   settle = 0;
   int                   cur_test = 0;
   int                   err_test = 0;
   int                   err_total = 0;
   int                   check_count = 0;

   task automatic compare(input string name, input logic [DAT_W-1:0] exp, act);
      check_count++;
      if (exp !== act)
      begin
         $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
         err_test++;
         err_total++;
      end
   endtask

   // --------------------------------------------------
   // Reference model, one step per rising edge
   // --------------------------------------------------
   always @(posedge ilaunch_clk)
   begin
      if (test_num != cur_test)
      begin
         if (cur_test > 0)
            $display("Test %0d finished with %0d errors", cur_test, err_test);
         cur_test = test_num;
         err_test = 0;
      end
      if (!irstb)
      begin
         for (int i = 0; i < NUM_LANES; i++)
            cfg[i] = '0;
         settle  = 0;
         prev_rx = '0;
         e_ack   = 1'b0;
      end
      else
      begin
         compare("wb_ack", DAT_W'(e_ack), DAT_W'(wb_ack));
         e_ack = wb_cyc & wb_stb & ~e_ack;   // One ack after each new request
         if (wb_ack && wb_we && wb_adr < 3'd4)
         begin
            cfg[wb_adr[1:0]] = wb_wdata & 8'h3f;   // Write landed one edge ago
            settle = 0;
         end
         else if (wb_ack && !wb_we)
            compare("wb_rdata", (wb_adr < 3'd4) ? cfg[wb_adr[1:0]] :
                    (wb_adr == 3'd4) ? DAT_W'(prev_rx) : '0, wb_rdata);
         for (int i = 0; i < NUM_LANES; i++)
         begin
            e_oe[i]  = cfg[i][0];
            e_pad[i] = cfg[i][0] & ((cfg[i][3:2] == 2'd2) ? async_data[i] : d0_h[0][i]);
            m_pad[i] = !cfg[i][0] || cfg[i][3:2] == 2'd2 || settle >= 4;
            if (cfg[i][0])
               e_lvl[i] = e_pad[i];
            else if (pad_ext_en[i])
               e_lvl[i] = pad_in[i];
            else
               e_lvl[i] = cfg[i][4] & cfg[i][5];   // Weak keeper or low
            e_lvl[i] = e_lvl[i] & cfg[i][1];
            if (cfg[i][3:2] == 2'd1)
            begin
               e_d0[i] = cfg[i][1] & d0_h[2][i];   // DDR pair two cycles late
               e_d1[i] = cfg[i][1] & d1_h[2][i];
            end
            else
            begin
               e_d0[i] = cfg[i][1] & d0_h[1][i];   // SDR one cycle late
               e_d1[i] = 1'b0;
            end
            m_rxd[i] = !cfg[i][1] || (cfg[i][0] && cfg[i][3:2] != 2'd2 && settle >= 4);
         end
         compare("pad_oe", DAT_W'(e_oe), DAT_W'(pad_oe));
         compare("pad_out", DAT_W'(e_pad & m_pad), DAT_W'(pad_out & m_pad));
         compare("rx_async", DAT_W'(e_lvl & m_pad), DAT_W'(rx_async & m_pad));
         compare("rx_dat0", DAT_W'(e_d0 & m_rxd), DAT_W'(rx_dat0 & m_rxd));
         compare("rx_dat1", DAT_W'(e_d1 & m_rxd), DAT_W'(rx_dat1 & m_rxd));
         prev_rx = e_lvl;
         if (settle < 4)
            settle++;
      end
      d0_h[2] = d0_h[1];
      d0_h[1] = d0_h[0];
      d0_h[0] = tx_dat0;   // Value the DUT takes at this edge
      d1_h[2] = d1_h[1];
      d1_h[1] = d1_h[0];
      d1_h[0] = tx_dat1;
   end

endmodule

//--- verification/aib_props.sv
// Bound once per buffer and once to the CSR; unused inputs of each binding are tied low
module aib_props
(
   input logic ilaunch_clk,
   input logic irstb,
   input logic oe,     // Buffer pad_oe
   input logic txen,   // Buffer txen
   input logic ack,    // CSR wb_ack
   input logic stb     // CSR wb_stb
);
   timeunit 1ns;
   timeprecision 100ps;

   // --------------------------------------------------
   // Pad driver and bus handshake
   // --------------------------------------------------
   a_oe_needs_txen : assert property (@(posedge ilaunch_clk) disable iff (!irstb)
      oe |-> txen) else $error("pad_oe high while txen is low");

   a_ack_one_cycle : assert property (@(posedge ilaunch_clk) disable iff (!irstb)
      ack |=> !ack) else $error("wb_ack held longer than one cycle");

   a_ack_needs_stb : assert property (@(posedge ilaunch_clk) disable iff (!irstb)
      ack |-> $past(stb)) else $error("wb_ack given without a strobe");

endmodule

bind aib_io_buffer aib_props i_buf_props
(
   .ilaunch_clk (ilaunch_clk),
   .irstb       (irstb),
   .oe          (pad_oe),
   .txen        (txen),
   .ack         (1'b0),
   .stb         (1'b0)
);

bind aib_csr aib_props i_csr_props
(
   .ilaunch_clk (ilaunch_clk),
   .irstb       (irstb),
   .oe          (1'b0),
   .txen        (1'b0),
   .ack         (wb_ack),
   .stb         (wb_stb)
);

//--- verification/aib_tb.sv
// Inputs change on falling edges only; the watchdog limit follows TEST_CYCLES
module aib_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import aib_pkg::*;

   localparam int ACCESS_CYCLES = 3;   // Setup, ack and release of one bus access
   localparam int TEST_CYCLES   = 5 + 38 * ACCESS_CYCLES + 202 + 2;   // Reset, accesses, random, flush

   logic ilaunch_clk, irstb, wb_cyc, wb_stb, wb_we, wb_ack;
   logic [ADR_W-1:0]     wb_adr;
   logic [DAT_W-1:0]     wb_wdata, wb_rdata;
   logic [NUM_LANES-1:0] tx_dat0, tx_dat1, async_data, pad_in, pad_ext_en;
   logic [NUM_LANES-1:0] rx_dat0, rx_dat1, rx_async, pad_out, pad_oe;
   logic [31:0]          seed;
   int                   test_num;
   int                   tb_errs;
   int                   total;

   always #50 ilaunch_clk = ~ilaunch_clk;

   aib_channel i_aib_channel (.*);

   aib_checker i_checker
   (
      .ilaunch_clk, .irstb, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata, .wb_ack,
      .tx_dat0, .tx_dat1, .async_data, .pad_in, .pad_ext_en,
      .rx_dat0, .rx_dat1, .rx_async, .pad_out, .pad_oe, .test_num
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // One Wishbone classic access, request dropped in the cycle after ack
   task automatic bus_access(input logic we, input logic [ADR_W-1:0] adr,
                             input logic [DAT_W-1:0] wdata);
      int waited;
      waited = 0;
      @(negedge ilaunch_clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_wdata = wdata;
      do
      begin
         @(negedge ilaunch_clk);
         waited++;
      end
      while (!wb_ack && waited < 10);
      if (!wb_ack)
      begin
         $display("Wishbone access to address %0d was never acknowledged", adr);
         tb_errs++;
      end
      else
         @(negedge ilaunch_clk);   // Request stays up through the ack edge
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic drive_random(input int cycles);
      repeat (cycles)
      begin
         @(negedge ilaunch_clk);
         seed       = xorshift32(seed);
         tx_dat0    = seed[3:0];
         tx_dat1    = seed[7:4];
         async_data = seed[11:8];
         pad_in     = seed[15:12];
         pad_ext_en = seed[19:16];
      end
   endtask

   task automatic config_all(input logic [DAT_W-1:0] cfg, input logic [DAT_W-1:0] rnd_mask);
      for (int i = 0; i < NUM_LANES; i++)
      begin
         seed = xorshift32(seed);
         bus_access(1'b1, ADR_W'(i), cfg | (seed[7:0] & rnd_mask));
      end
   endtask

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial
   begin
      ilaunch_clk = 1'b0;
      irstb = 1'b0;
      {wb_cyc, wb_stb, wb_we, wb_adr, wb_wdata} = '0;
      {tx_dat0, tx_dat1, async_data, pad_in, pad_ext_en} = '0;
      seed = 32'h94044f2e;
      test_num = 0;
      tb_errs = 0;
      repeat (5) @(negedge ilaunch_clk);
      irstb = 1'b1;
      test_num = 1;                        // Reset values, readback, unmapped reads
      for (int i = 0; i < NUM_LANES; i++)
      begin
         seed = xorshift32(seed);
         bus_access(1'b1, ADR_W'(i), seed[7:0]);
         bus_access(1'b0, ADR_W'(i), '0);
      end
      bus_access(1'b0, 3'd5, '0);
      bus_access(1'b0, 3'd7, '0);
      test_num = 2;                        // SDR loopback
      config_all(8'h03, 8'h00);
      drive_random(60);
      test_num = 3;                        // DDR loopback
      config_all(8'h07, 8'h00);
      drive_random(60);
      test_num = 4;                        // Async path and status
      config_all(8'h0b, 8'h00);
      repeat (8)
      begin
         drive_random(4);
         bus_access(1'b0, 3'd4, '0);
      end
      test_num = 5;                        // Far side and keeper, then rx off
      config_all(8'h02, 8'h30);
      drive_random(30);
      config_all(8'h00, 8'h30);
      drive_random(20);
      test_num = 6;                        // Flushes the last test line
      repeat (2) @(negedge ilaunch_clk);
      total = tb_errs + i_checker.err_total;
      $display("Tests: 5, checks: %0d, errors: %0d", i_checker.check_count, total);
      if (total == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   initial
   begin
      #(2 * TEST_CYCLES * 100);
      $display("Watchdog expired before the tests completed");
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule
